/* build.f */
+incdir+include
source/fft2d_pkg.sv
source/row_gather.sv
source/fft4_core.sv
source/corner_turn_buffer.sv
source/fft2d_ctrl.sv
source/sample_serializer.sv
source/fft2d_top.sv
tb/fft2d_props.sv
tb/fft2d_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   := build.f
TOP        := fft2d_tb
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Test OK" $(LOG)
	@! grep -q "Test FAILED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/fft2d_tb.sv */
`include "fft2d_params.svh"

module fft2d_tb;

  localparam int N        = `FFT2D_POINTS;
  localparam int IW       = `FFT2D_IN_W;
  localparam int OW       = `FFT2D_COL_W;
  localparam int PERIOD   = 4;
  localparam int N_FRAMES = 10;  // 1 + 1 + 3 + 4 + 1
  localparam int TIMEOUT  = (N_FRAMES * 40 + 200) * PERIOD;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 in_valid;
  logic                 in_ready;
  logic signed [IW-1:0] in_re;
  logic signed [IW-1:0] in_im;
  logic                 out_valid;
  logic                 out_ready;
  logic signed [OW-1:0] out_re;
  logic signed [OW-1:0] out_im;
  logic                 out_last;

  int frame_re [N*N];  // x[r][c] at r*N + c
  int frame_im [N*N];
  int exp_re [$];      // k2 outer, k1 inner
  int exp_im [$];
  bit exp_last [$];
  int e_re;
  int e_im;
  bit e_last;
  int n_errors;
  int n_outputs;
  bit in_gaps;     // idle cycles between input samples
  bit rand_ready;  // random stalls on the output
  bit no_gaps;     // output must not pause
  bit seen_out;

  fft2d_top dut_i (
    .clk(clk), .arst_n(arst_n),
    .in_valid(in_valid), .in_ready(in_ready), .in_re(in_re), .in_im(in_im),
    .out_valid(out_valid), .out_ready(out_ready), .out_re(out_re), .out_im(out_im),
    .out_last(out_last));

  always #(PERIOD/2) clk = ~clk;

  // Y[k1][k2] = sum of x[r][c] * (-j)^(c*k2 + r*k1)
  task automatic model_frame();
    int acc_re;
    int acc_im;
    int m;
    for (int k2 = 0; k2 < N; k2++)
      for (int k1 = 0; k1 < N; k1++)
      begin
        acc_re = 0;
        acc_im = 0;
        for (int r = 0; r < N; r++)
          for (int c = 0; c < N; c++)
          begin
            m = (c * k2 + r * k1) % 4;  // power of -j
            case (m)
              0:
              begin
                acc_re += frame_re[r*N+c];
                acc_im += frame_im[r*N+c];
              end
              1:
              begin
                acc_re += frame_im[r*N+c];  // (a + jb)(-j) = b - ja
                acc_im -= frame_re[r*N+c];
              end
              2:
              begin
                acc_re -= frame_re[r*N+c];
                acc_im -= frame_im[r*N+c];
              end
              default:
              begin
                acc_re -= frame_im[r*N+c];  // (a + jb)(j) = -b + ja
                acc_im += frame_re[r*N+c];
              end
            endcase
          end
        exp_re.push_back(acc_re);
        exp_im.push_back(acc_im);
        exp_last.push_back(k2 == N-1 && k1 == N-1);
      end
  endtask

  task automatic check_value(input string name, input logic [OW-1:0] got,
                             input logic [OW-1:0] exp);
    if (got !== exp)
    begin
      n_errors++;
      $display("Fail %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // reset values of the handshake outputs
  task automatic check_reset_state();
    check_value("in_ready", OW'(in_ready), '0);
    check_value("out_valid", OW'(out_valid), '0);
    check_value("out_last", OW'(out_last), '0);
  endtask

  // held until taken, then back at 1 unit after the edge
  task automatic send_sample(input int re, input int im);
    if (in_gaps && ($urandom % 4 == 0))
    begin
      in_valid = 1'b0;
      repeat (1 + $urandom % 3) @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_re    = IW'(re);
    in_im    = IW'(im);
    @(negedge clk);
    if (no_gaps && !in_ready)
    begin
      n_errors++;
      $display("input stalled during the back-to-back stream");
    end
    while (!in_ready)
      @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic send_frame();
    model_frame();
    for (int i = 0; i < N*N; i++)
      send_sample(frame_re[i], frame_im[i]);
    in_valid = 1'b0;
  endtask

  task automatic fill_frame(input int re, input int im);
    for (int i = 0; i < N*N; i++)
    begin
      frame_re[i] = re;
      frame_im[i] = im;
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < N*N; i++)
    begin
      frame_re[i] = int'($signed(IW'($urandom)));  // full signed range
      frame_im[i] = int'($signed(IW'($urandom)));
    end
  endtask

  // a few idle cycles catch extra outputs
  task automatic wait_drain();
    while (exp_re.size() != 0)
      @(negedge clk);
    repeat (8) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic check_model(input int idx, input int re, input int im);
    check_value($sformatf("exp_re[%0d]", idx), OW'(exp_re[idx]), OW'(re));
    check_value($sformatf("exp_im[%0d]", idx), OW'(exp_im[idx]), OW'(im));
  endtask

  task automatic test_impulse();
    fill_frame(0, 0);
    frame_re[0] = 'h1234;
    frame_im[0] = 'h0100;
    send_frame();
    for (int i = 0; i < N*N; i++)
      check_model(i, 'h1234, 'h0100);  // flat spectrum
    wait_drain();
  endtask

  task automatic test_constant();
    fill_frame(5, -3);
    send_frame();
    check_model(0, 80, -48);  // 16 * x at DC
    for (int i = 1; i < N*N; i++)
      check_model(i, 0, 0);
    wait_drain();
  endtask

  task automatic test_stream();
    no_gaps  = 1'b1;
    seen_out = 1'b0;
    for (int f = 0; f < 3; f++)
    begin
      fill_random();
      send_frame();
    end
    wait_drain();
    no_gaps = 1'b0;
  endtask

  task automatic test_backpressure();
    in_gaps    = 1'b1;
    rand_ready = 1'b1;
    for (int f = 0; f < 4; f++)
    begin
      fill_random();
      send_frame();
    end
    wait_drain();
    in_gaps    = 1'b0;
    rand_ready = 1'b0;
  endtask

  task automatic test_extremes();
    fill_frame(-32768, -32768);
    send_frame();
    check_model(0, -524288, -524288);  // needs all 20 bits
    for (int i = 1; i < N*N; i++)
      check_model(i, 0, 0);
    wait_drain();
  endtask

  // sampled at the falling edge, away from driven changes
  always @(negedge clk)
  begin
    if (no_gaps && seen_out && exp_re.size() != 0 && !out_valid)
    begin
      n_errors++;
      $display("output stream paused while data was still expected");
    end
    if (arst_n && out_valid && out_ready)
    begin
      n_outputs++;
      seen_out = no_gaps;
      if (exp_re.size() == 0)
      begin
        n_errors++;
        $display("output transfer with no sample expected");
      end
      else
      begin
        e_re   = exp_re.pop_front();
        e_im   = exp_im.pop_front();
        e_last = exp_last.pop_front();
        check_value("out_re", out_re, OW'(e_re));
        check_value("out_im", out_im, OW'(e_im));
        check_value("out_last", OW'(out_last), OW'(e_last));
      end
    end
  end

  initial
  begin
    out_ready = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      out_ready = rand_ready ? ($urandom % 4 != 0) : 1'b1;  // about 3 in 4
    end
  end

  initial
  begin
    #(TIMEOUT);
    $display("timeout: the frames did not come out in time, outputs: %0d, errors: %0d",
             n_outputs, n_errors);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(83));
    n_errors  = 0;
    n_outputs = 0;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_re     = '0;
    in_im     = '0;
    @(posedge clk);
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_impulse();
    test_constant();
    test_stream();
    test_backpressure();
    test_extremes();
    if (n_outputs != N_FRAMES * N * N)
    begin
      n_errors++;
      $display("wrong number of output samples: %0d", n_outputs);
    end
    $display("outputs: %0d, errors: %0d", n_outputs, n_errors);
    if (n_errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* tb/fft2d_props.sv */
`include "fft2d_params.svh"

module fft2d_props (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    out_valid,
  input logic                    out_ready,
  input logic [`FFT2D_COL_W-1:0] out_re,
  input logic [`FFT2D_COL_W-1:0] out_im,
  input logic                    out_last
);

  // stalled sample held until taken
  hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_re) && $stable(out_im)
      && $stable(out_last))
    else $error("output sample changed while out_ready was low");

  // nothing leaves right after reset
  reset_a: assert property (@(posedge clk) !arst_n |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  last_a: assert property (@(posedge clk) disable iff (!arst_n)
    out_last |-> out_valid)  // frame marker rides on a sample
    else $error("out_last high without out_valid");

endmodule

bind fft2d_top fft2d_props props_i (
  .clk(clk),
  .arst_n(arst_n),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .out_re(out_re),
  .out_im(out_im),
  .out_last(out_last)
);

/* source/fft2d_top.sv */
`include "fft2d_params.svh"

module fft2d_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic signed [`FFT2D_IN_W-1:0]  in_re,
  input  logic signed [`FFT2D_IN_W-1:0]  in_im,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic signed [`FFT2D_COL_W-1:0] out_re,
  output logic signed [`FFT2D_COL_W-1:0] out_im,
  output logic                          out_last
);

  fft2d_pkg::cplx_in_t  in_sample;
  logic                 g_valid;     // gathered row
  logic                 g_ready;
  fft2d_pkg::vec_in_t   g_vec;
  logic                 r_valid;     // row fft result
  logic                 r_ready;
  fft2d_pkg::vec_row_t  r_vec;
  logic                 c_in_valid;  // column out of the buffer
  logic                 c_in_ready;
  fft2d_pkg::vec_row_t  ct_rd_data;
  logic                 c_valid;     // column fft result
  logic                 c_ready;
  fft2d_pkg::vec_col_t  c_vec;
  fft2d_pkg::cplx_col_t o_sample;

  ct_if ct_bus ();

  assign in_sample.re = in_re;
  assign in_sample.im = in_im;
  assign out_re       = o_sample.re;
  assign out_im       = o_sample.im;

  row_gather gather_i (.clk(clk), .arst_n(arst_n),
    .in_valid(in_valid), .in_ready(in_ready), .in_sample(in_sample),
    .vec_valid(g_valid), .vec_ready(g_ready), .vec_data(g_vec));

  fft4_core #(.in_t(fft2d_pkg::cplx_in_t), .out_t(fft2d_pkg::cplx_row_t)) row_fft_i (
    .clk(clk), .arst_n(arst_n),
    .in_valid(g_valid), .in_ready(g_ready), .in_vec(g_vec),
    .out_valid(r_valid), .out_ready(r_ready), .out_vec(r_vec));

  fft2d_ctrl ctrl_i (.clk(clk), .arst_n(arst_n),
    .row_valid(r_valid), .row_ready(r_ready),
    .col_valid(c_in_valid), .col_ready(c_in_ready), .ct(ct_bus));

  corner_turn_buffer ctb_i (.clk(clk), .arst_n(arst_n), .ct(ct_bus),
    .wr_data(r_vec), .rd_data(ct_rd_data));  // row in, column out

  fft4_core #(.in_t(fft2d_pkg::cplx_row_t), .out_t(fft2d_pkg::cplx_col_t)) col_fft_i (
    .clk(clk), .arst_n(arst_n),
    .in_valid(c_in_valid), .in_ready(c_in_ready), .in_vec(ct_rd_data),
    .out_valid(c_valid), .out_ready(c_ready), .out_vec(c_vec));

  sample_serializer ser_i (.clk(clk), .arst_n(arst_n),
    .vec_valid(c_valid), .vec_ready(c_ready), .vec_data(c_vec),
    .out_valid(out_valid), .out_ready(out_ready), .out_sample(o_sample),
    .out_last(out_last));

endmodule

/* source/sample_serializer.sv */
`include "fft2d_params.svh"

module sample_serializer (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 vec_valid,
  output logic                 vec_ready,
  input  fft2d_pkg::vec_col_t  vec_data,
  output logic                 out_valid,
  input  logic                 out_ready,
  output fft2d_pkg::cplx_col_t out_sample,
  output logic                 out_last
);

  localparam int IW   = $clog2(`FFT2D_POINTS);
  localparam int LAST = `FFT2D_POINTS - 1;

  fft2d_pkg::vec_col_t vec_q;      // column being sent
  logic                full;       // vec_q holds unsent samples
  logic [IW-1:0]       elem;       // k1 of current sample
  logic [IW-1:0]       vcnt;       // k2, vectors done in frame
  logic                last_elem;
  logic                out_fire;

  assign last_elem  = (elem == IW'(LAST));
  assign out_valid  = full;
  assign out_sample = vec_q[elem];
  assign out_last   = full && last_elem && (vcnt == IW'(LAST));  // 16th sample
  assign out_fire   = out_valid && out_ready;
  // reload on the final sample so there is no bubble
  assign vec_ready  = !full || (out_ready && last_elem);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      full <= 1'b0;
      elem <= '0;
      vcnt <= '0;
    end
    else
    begin
      if (vec_valid && vec_ready)
        full <= 1'b1;
      else if (out_fire && last_elem)
        full <= 1'b0;  // emptied, nothing waiting
      if (out_fire)
      begin
        elem <= last_elem ? '0 : elem + 1'b1;
        if (last_elem)
          vcnt <= (vcnt == IW'(LAST)) ? '0 : vcnt + 1'b1;  // next frame
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (vec_valid && vec_ready)
      vec_q <= vec_data;
  end

endmodule

/* source/fft2d_ctrl.sv */
`include "fft2d_params.svh"

module fft2d_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic row_valid,  // row fft output valid
  output logic row_ready,
  output logic col_valid,  // column fft input valid
  input  logic col_ready,
  ct_if.ctrl   ct
);

  localparam int IW   = $clog2(`FFT2D_POINTS);
  localparam int LAST = `FFT2D_POINTS - 1;

  logic [1:0]    full;     // per-bank full flag
  logic          wr_bank;  // bank taking rows
  logic [IW-1:0] wr_row;
  logic          rd_bank;  // bank giving columns
  logic [IW-1:0] rd_col;
  logic          row_fire;
  logic          row_done; // last row of a bank written
  logic          col_fire;
  logic          col_done; // last column of a bank read

  // rows only go into a free bank
  assign row_ready = !full[wr_bank];
  assign row_fire  = row_valid && row_ready;
  assign row_done  = row_fire && (wr_row == IW'(LAST));

  // columns only come from a full bank
  assign col_valid = full[rd_bank];
  assign col_fire  = col_valid && col_ready;
  assign col_done  = col_fire && (rd_col == IW'(LAST));

  assign ct.wr_en   = row_fire;
  assign ct.wr_bank = wr_bank;
  assign ct.wr_row  = wr_row;
  assign ct.rd_bank = rd_bank;
  assign ct.rd_col  = rd_col;

  // set and clear never hit the same bank in one cycle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      full <= '0;
    else
    begin
      if (row_done)
        full[wr_bank] <= 1'b1;  // bank handed to column side
      if (col_done)
        full[rd_bank] <= 1'b0;  // bank free for rows again
    end
  end

  // write side
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_bank <= 1'b0;
      wr_row  <= '0;
    end
    else if (row_fire)
    begin
      if (row_done)
      begin
        wr_row  <= '0;
        wr_bank <= ~wr_bank;  // ping-pong
      end
      else
        wr_row <= wr_row + 1'b1;
    end
  end

  // read side
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_bank <= 1'b0;
      rd_col  <= '0;
    end
    else if (col_fire)
    begin
      if (col_done)
      begin
        rd_col  <= '0;
        rd_bank <= ~rd_bank;  // follow the writer
      end
      else
        rd_col <= rd_col + 1'b1;
    end
  end

endmodule

/* source/corner_turn_buffer.sv */
`include "fft2d_params.svh"

// bank and index controls between fft2d_ctrl and the buffer
interface ct_if;
  logic                             wr_en;    // store one row vector
  logic                             wr_bank;
  logic [$clog2(`FFT2D_POINTS)-1:0] wr_row;
  logic                             rd_bank;
  logic [$clog2(`FFT2D_POINTS)-1:0] rd_col;   // column presented on rd_data

  modport ctrl (output wr_en, wr_bank, wr_row, rd_bank, rd_col);
  modport mem  (input  wr_en, wr_bank, wr_row, rd_bank, rd_col);
endinterface

module corner_turn_buffer (
  input  logic                clk,
  input  logic                arst_n,
  ct_if.mem                   ct,
  input  fft2d_pkg::vec_row_t wr_data,
  output fft2d_pkg::vec_row_t rd_data
);

  // two banks of POINTS rows by POINTS columns
  fft2d_pkg::cplx_row_t mem [2][`FFT2D_POINTS][`FFT2D_POINTS];

  logic wr_ok;

  assign wr_ok = ct.wr_en && arst_n;  // no writes while held in reset

  // whole row in one edge
  always_ff @(posedge clk)
  begin
    if (wr_ok)
    begin
      for (int c = 0; c < `FFT2D_POINTS; c++)
        mem[ct.wr_bank][ct.wr_row][c] <= wr_data[c];
    end
  end

  // corner turn, element rd_col of every row in rd_bank
  always_comb
  begin
    for (int r = 0; r < `FFT2D_POINTS; r++)
      rd_data[r] = mem[ct.rd_bank][r][ct.rd_col];  // row r becomes element r
  end

endmodule

/* source/fft4_core.sv */
`include "fft2d_params.svh"

module fft4_core #(
  parameter type in_t  = fft2d_pkg::cplx_in_t,
  parameter type out_t = fft2d_pkg::cplx_row_t
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  in_t  [`FFT2D_POINTS-1:0] in_vec,
  output logic                     out_valid,
  input  logic                     out_ready,
  output out_t [`FFT2D_POINTS-1:0] out_vec
);

  localparam int OW = $bits(out_t) / 2;  // output part width

  logic signed [OW-1:0] xr [`FFT2D_POINTS];  // sign-extended inputs
  logic signed [OW-1:0] xi [`FFT2D_POINTS];
  logic signed [OW-1:0] ar;  // x0 + x2
  logic signed [OW-1:0] ai;
  logic signed [OW-1:0] br;  // x1 + x3
  logic signed [OW-1:0] bi;
  logic signed [OW-1:0] cr;  // x0 - x2
  logic signed [OW-1:0] ci;
  logic signed [OW-1:0] dr;  // x1 - x3
  logic signed [OW-1:0] di;
  out_t [`FFT2D_POINTS-1:0] y;  // unregistered result

  always_comb
  begin
    for (int n = 0; n < `FFT2D_POINTS; n++)
    begin
      xr[n] = in_vec[n].re;  // signed field widens with sign
      xi[n] = in_vec[n].im;
    end
    ar = xr[0] + xr[2];
    ai = xi[0] + xi[2];
    br = xr[1] + xr[3];
    bi = xi[1] + xi[3];
    cr = xr[0] - xr[2];
    ci = xi[0] - xi[2];
    dr = xr[1] - xr[3];
    di = xi[1] - xi[3];
    y[0].re = ar + br;  // DC bin
    y[0].im = ai + bi;
    y[1].re = cr + di;  // c - j*d
    y[1].im = ci - dr;
    y[2].re = ar - br;  // alternating signs
    y[2].im = ai - bi;
    y[3].re = cr - di;  // c + j*d
    y[3].im = ci + dr;
  end

  // one stage of buffering, full rate when drained every cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      out_valid <= 1'b0;
    else if (in_valid && in_ready)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;  // drained with nothing behind it
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
      out_vec <= y;       // held while out_ready is low
  end

endmodule

/* source/row_gather.sv */
`include "fft2d_params.svh"

module row_gather (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  fft2d_pkg::cplx_in_t  in_sample,
  output logic                 vec_valid,
  input  logic                 vec_ready,
  output fft2d_pkg::vec_in_t   vec_data
);

  localparam int IW   = $clog2(`FFT2D_POINTS);
  localparam int LAST = `FFT2D_POINTS - 1;

  logic [IW-1:0]      pos;       // column index of next sample
  logic               in_fire;
  logic               row_done;  // fourth sample of a row taken
  fft2d_pkg::vec_in_t vec_q;     // shift register

  // keep taking samples while the waiting vector leaves this cycle
  assign in_ready = arst_n && (!vec_valid || vec_ready);  // closed in reset
  assign in_fire  = in_valid && in_ready;
  assign row_done = in_fire && (pos == IW'(LAST));
  assign vec_data = vec_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pos       <= '0;
      vec_valid <= 1'b0;
    end
    else
    begin
      if (in_fire)
        pos <= row_done ? '0 : pos + 1'b1;  // wrap per row
      if (row_done)
        vec_valid <= 1'b1;                  // full row ready next cycle
      else if (vec_ready)
        vec_valid <= 1'b0;                  // taken downstream
    end
  end

  // new sample enters at the top, sample 0 ends at index 0
  always_ff @(posedge clk)
  begin
    if (in_fire)
      vec_q <= {in_sample, vec_q[`FFT2D_POINTS-1:1]};
  end

endmodule

/* source/fft2d_pkg.sv */
`include "fft2d_params.svh"

package fft2d_pkg;

  // im in the upper half, re in the lower half of each word
  typedef struct packed {
    logic signed [`FFT2D_IN_W-1:0] im;   // imaginary part
    logic signed [`FFT2D_IN_W-1:0] re;   // real part
  } cplx_in_t;

  typedef struct packed {
    logic signed [`FFT2D_ROW_W-1:0] im;  // after row pass
    logic signed [`FFT2D_ROW_W-1:0] re;
  } cplx_row_t;

  typedef struct packed {
    logic signed [`FFT2D_COL_W-1:0] im;  // after column pass
    logic signed [`FFT2D_COL_W-1:0] re;
  } cplx_col_t;

  // element n sits at index n
  typedef cplx_in_t  [`FFT2D_POINTS-1:0] vec_in_t;   // one input row
  typedef cplx_row_t [`FFT2D_POINTS-1:0] vec_row_t;  // row or column of R
  typedef cplx_col_t [`FFT2D_POINTS-1:0] vec_col_t;  // one output column

endpackage

/* include/fft2d_params.svh */
`ifndef FFT2D_PARAMS_SVH
`define FFT2D_PARAMS_SVH

// frame is FFT2D_POINTS x FFT2D_POINTS complex samples
`define FFT2D_POINTS 4

// part widths per stage
`define FFT2D_IN_W 16

// row pass adds 2 bits of growth
`define FFT2D_ROW_W 18

// column pass adds 2 more
`define FFT2D_COL_W 20

`endif
